/* verilog/video_pkg.sv */
// ####################################################################
// Video package
// Shared vector types and layer constants for the tile video block
// ####################################################################

package video_pkg;

    // Screen counters
    typedef logic [8:0] h_t;
    typedef logic [7:0] v_t;

    // CPU bus
    typedef logic [10:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;

    // One colour component
    typedef logic [3:0] rgb_t;

    // Layer pixels, palette bits on top of colour bits
    typedef logic [3:0] char_pxl_t;
    typedef logic [5:0] scr_pxl_t;

    // Palette PROM index
    typedef logic [7:0] pal_idx_t;

    // Graphics ROM addresses
    typedef logic [11:0] char_rom_addr_t;
    typedef logic [13:0] scr_rom_addr_t;

    // Character pixels live in the upper half of the palette
    localparam pal_idx_t char_pal_base = 8'h80;

endpackage

/* verilog/video_char.sv */
// ####################################################################
// Character layer
// 8x8 text tiles: CPU tile RAM, graphics ROM fetch and pixel shifter
// ####################################################################

`timescale 1ns/1ps

module video_char (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen6,
    input  video_pkg::h_t             h,
    input  video_pkg::v_t             v,
    input  logic                      flip,
    input  video_pkg::cpu_addr_t      cpu_addr,
    input  video_pkg::byte_t          cpu_din,
    input  logic                      cpu_wr,
    input  logic                      cpu_rd,
    input  logic                      char_cs,
    input  logic [15:0]               char_data,
    output video_pkg::byte_t          chram_dout,
    output video_pkg::char_rom_addr_t char_addr,
    output video_pkg::char_pxl_t      char_pxl
);

    // Codes in 0-1023, attributes in 1024-2047
    video_pkg::byte_t ram [0:2047];

    logic [7:0]       hpos;
    video_pkg::v_t    vpos;
    logic [9:0]       map_addr;

    video_pkg::byte_t code_r;
    video_pkg::byte_t attr_r;
    logic [2:0]       row_r;
    logic             flip_r;

    logic [7:0]       pl0_sh;
    logic [7:0]       pl1_sh;
    logic [1:0]       pal_sh;
    logic             flip_sh;

    logic             load;
    logic [7:0]       pl0;
    logic [7:0]       pl1;
    logic [1:0]       pal;
    logic             hflip;

    // Screen position as seen by the map
    assign hpos     = flip ? ~h[7:0] : h[7:0];
    assign vpos     = flip ? ~v : v;
    assign map_addr = {vpos[7:3], hpos[7:3]};

    always_ff @(posedge clk) begin
        if (cpu_wr && char_cs) begin
            ram[cpu_addr] <= cpu_din;
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chram_dout <= '0;
        end else if (cpu_rd && char_cs) begin
            chram_dout <= ram[cpu_addr];
        end
    end

    // Code and attribute ahead of the shifter
    always_ff @(posedge clk) begin
        if (cen6) begin
            code_r <= ram[{1'b0, map_addr}];
            attr_r <= ram[{1'b1, map_addr}];
            row_r  <= vpos[2:0];
            flip_r <= flip;
        end
    end

    assign char_addr = {attr_r[7], code_r, row_r};

    // New tile row enters on the tick after each tile boundary
    assign load  = h[2:0] == 3'd1;
    assign pl1   = load ? char_data[15:8] : pl1_sh;
    assign pl0   = load ? char_data[7:0] : pl0_sh;
    assign pal   = load ? attr_r[1:0] : pal_sh;
    assign hflip = load ? flip_r : flip_sh;

    always_ff @(posedge clk) begin
        if (cen6) begin
            pl1_sh  <= hflip ? pl1 >> 1 : pl1 << 1;
            pl0_sh  <= hflip ? pl0 >> 1 : pl0 << 1;
            pal_sh  <= pal;
            flip_sh <= hflip;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_pxl <= '0;
        end else if (cen6) begin
            char_pxl <= hflip ? {pal, pl1[0], pl0[0]} : {pal, pl1[7], pl0[7]};
        end
    end

endmodule

/* verilog/video_scroll.sv */
// ####################################################################
// Scroll layer
// 16x16 background tiles with vertical scroll, three bitplanes,
// fetched from the graphics ROM one half-row at a time
// ####################################################################

`timescale 1ns/1ps

module video_scroll (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen6,
    input  video_pkg::h_t            h,
    input  video_pkg::v_t            v,
    input  logic                     flip,
    input  video_pkg::cpu_addr_t     cpu_addr,
    input  video_pkg::byte_t         cpu_din,
    input  logic                     cpu_wr,
    input  logic                     cpu_rd,
    input  logic                     scr_cs,
    input  logic [1:0]               scrpos_cs,
    input  logic [23:0]              scrom_data,
    output video_pkg::byte_t         scram_dout,
    output video_pkg::scr_rom_addr_t scr_addr,
    output video_pkg::scr_pxl_t      scr_pxl
);

    // Codes in 0-511, attributes in 512-1023
    video_pkg::byte_t ram [0:1023];

    // Vertical scroll position, modulo 512
    logic [8:0]       scr_pos;

    logic [7:0]       hpos;
    video_pkg::v_t    vpos;
    logic [8:0]       vscr;
    logic [8:0]       map_addr;

    video_pkg::byte_t code_r;
    video_pkg::byte_t attr_r;
    logic [3:0]       row_r;
    logic             half_r;
    logic             flip_r;

    logic [23:0]      pl_sh;
    logic [2:0]       pal_sh;
    logic             flip_sh;

    logic             load;
    logic [23:0]      pl;
    logic [2:0]       pal;
    logic             hflip;

    assign hpos     = flip ? ~h[7:0] : h[7:0];
    assign vpos     = flip ? ~v : v;
    assign vscr     = {1'b0, vpos} + scr_pos;
    assign map_addr = {vscr[8:4], hpos[7:4]};

    always_ff @(posedge clk) begin
        if (cpu_wr && scr_cs) begin
            ram[cpu_addr[9:0]] <= cpu_din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scram_dout <= '0;
        end else if (cpu_rd && scr_cs) begin
            scram_dout <= ram[cpu_addr[9:0]];
        end
    end

    // scrpos_cs[0] takes the low byte, scrpos_cs[1] the high bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scr_pos <= '0;
        end else if (cpu_wr) begin
            if (scrpos_cs[0]) begin
                scr_pos[7:0] <= cpu_din;
            end
            if (scrpos_cs[1]) begin
                scr_pos[8] <= cpu_din[0];
            end
        end
    end

    // Map lookup for the half tile under the current column
    always_ff @(posedge clk) begin
        if (cen6) begin
            code_r <= ram[{1'b0, map_addr}];
            attr_r <= ram[{1'b1, map_addr}];
            row_r  <= vscr[3:0];
            half_r <= hpos[3];
            flip_r <= flip;
        end
    end

    assign scr_addr = {attr_r[7], code_r, row_r, half_r};

    // Each half tile is eight pixels, loaded like a character row
    assign load  = h[2:0] == 3'd1;
    assign pl    = load ? scrom_data : pl_sh;
    assign pal   = load ? attr_r[2:0] : pal_sh;
    assign hflip = load ? flip_r : flip_sh;

    always_ff @(posedge clk) begin
        if (cen6) begin
            pl_sh[23:16] <= hflip ? pl[23:16] >> 1 : pl[23:16] << 1;
            pl_sh[15:8]  <= hflip ? pl[15:8] >> 1 : pl[15:8] << 1;
            pl_sh[7:0]   <= hflip ? pl[7:0] >> 1 : pl[7:0] << 1;
            pal_sh       <= pal;
            flip_sh      <= hflip;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scr_pxl <= '0;
        end else if (cen6) begin
            if (hflip) begin
                scr_pxl <= {pal, pl[16], pl[8], pl[0]};
            end else begin
                scr_pxl <= {pal, pl[23], pl[15], pl[7]};
            end
        end
    end

endmodule

/* verilog/video_colmix.sv */
// ####################################################################
// Colour mixer
// Layer priority, RGB palette PROMs and blanked output register
// ####################################################################

`timescale 1ns/1ps

module video_colmix (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen6,
    input  logic                 lhbl,
    input  logic                 lvbl,
    input  video_pkg::char_pxl_t char_pxl,
    input  video_pkg::scr_pxl_t  scr_pxl,
    input  video_pkg::pal_idx_t  prog_addr,
    input  video_pkg::rgb_t      prog_din,
    input  logic                 prom_red_we,
    input  logic                 prom_green_we,
    input  logic                 prom_blue_we,
    output video_pkg::rgb_t      red,
    output video_pkg::rgb_t      green,
    output video_pkg::rgb_t      blue
);

    video_pkg::rgb_t     prom_red   [0:255];
    video_pkg::rgb_t     prom_green [0:255];
    video_pkg::rgb_t     prom_blue  [0:255];

    video_pkg::pal_idx_t pal_idx;

    // Colour 0 in the text layer lets the background through
    always_comb begin
        if (char_pxl[1:0] == 2'd0) begin
            pal_idx = {2'b00, scr_pxl};
        end else begin
            pal_idx = video_pkg::char_pal_base + {4'd0, char_pxl};
        end
    end

    // Loaded once at start-up, one entry per strobe
    always_ff @(posedge clk) begin
        if (prom_red_we) begin
            prom_red[prog_addr] <= prog_din;
        end
        if (prom_green_we) begin
            prom_green[prog_addr] <= prog_din;
        end
        if (prom_blue_we) begin
            prom_blue[prog_addr] <= prog_din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (cen6) begin
            if (!lhbl || !lvbl) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= prom_red[pal_idx];
                green <= prom_green[pal_idx];
                blue  <= prom_blue[pal_idx];
            end
        end
    end

endmodule

/* verilog/video_top.sv */
// ####################################################################
// Tile video top level
// Character layer and scroll layer feeding the colour mixer
// ####################################################################

`timescale 1ns/1ps

module video_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen6,
    input  video_pkg::h_t             h,
    input  video_pkg::v_t             v,
    input  logic                      flip,
    // CPU bus
    input  video_pkg::cpu_addr_t      cpu_addr,
    input  video_pkg::byte_t          cpu_din,
    input  logic                      cpu_wr,
    input  logic                      cpu_rd,
    input  logic                      char_cs,
    input  logic                      scr_cs,
    input  logic [1:0]                scrpos_cs,
    output video_pkg::byte_t          chram_dout,
    output video_pkg::byte_t          scram_dout,
    // Graphics ROMs
    output video_pkg::char_rom_addr_t char_addr,
    input  logic [15:0]               char_data,
    output video_pkg::scr_rom_addr_t  scr_addr,
    input  logic [23:0]               scrom_data,
    // Blanking and palette load
    input  logic                      lhbl,
    input  logic                      lvbl,
    input  video_pkg::pal_idx_t       prog_addr,
    input  video_pkg::rgb_t           prog_din,
    input  logic                      prom_red_we,
    input  logic                      prom_green_we,
    input  logic                      prom_blue_we,
    output video_pkg::rgb_t           red,
    output video_pkg::rgb_t           green,
    output video_pkg::rgb_t           blue
);

    video_pkg::char_pxl_t char_pxl;
    video_pkg::scr_pxl_t  scr_pxl;

    video_char u_char (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .h          ( h          ),
        .v          ( v          ),
        .flip       ( flip       ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_din    ( cpu_din    ),
        .cpu_wr     ( cpu_wr     ),
        .cpu_rd     ( cpu_rd     ),
        .char_cs    ( char_cs    ),
        .char_data  ( char_data  ),
        .chram_dout ( chram_dout ),
        .char_addr  ( char_addr  ),
        .char_pxl   ( char_pxl   )
    );

    video_scroll u_scroll (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen6       ( cen6       ),
        .h          ( h          ),
        .v          ( v          ),
        .flip       ( flip       ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_din    ( cpu_din    ),
        .cpu_wr     ( cpu_wr     ),
        .cpu_rd     ( cpu_rd     ),
        .scr_cs     ( scr_cs     ),
        .scrpos_cs  ( scrpos_cs  ),
        .scrom_data ( scrom_data ),
        .scram_dout ( scram_dout ),
        .scr_addr   ( scr_addr   ),
        .scr_pxl    ( scr_pxl    )
    );

    video_colmix u_colmix (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cen6          ( cen6          ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .char_pxl      ( char_pxl      ),
        .scr_pxl       ( scr_pxl       ),
        .prog_addr     ( prog_addr     ),
        .prog_din      ( prog_din      ),
        .prom_red_we   ( prom_red_we   ),
        .prom_green_we ( prom_green_we ),
        .prom_blue_we  ( prom_blue_we  ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          )
    );

endmodule

/* tests/tb_clock.sv */
// ####################################################################
// Testbench clock
// Free-running 100 ns clock for the tile video testbench
// ####################################################################

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 50ns;

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

/* tests/video_checker.sv */
// ####################################################################
// Video output checker
// Assertions on the RGB outputs of the tile video top level
// ####################################################################

`timescale 1ns/1ps

module video_checker (
    input logic            clk,
    input logic            rst_n,
    input logic            cen6,
    input logic            lhbl,
    input logic            lvbl,
    input video_pkg::rgb_t red,
    input video_pkg::rgb_t green,
    input video_pkg::rgb_t blue
);

    // Synchronous reset clears the colour register on the next edge
    rgb_reset_zero: assert property (@(posedge clk)
        !rst_n |=> (red == '0 && green == '0 && blue == '0))
        else $error("RGB not zero after a reset edge");

    // Blanking sampled on a pixel tick forces black
    rgb_blank_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (cen6 && (!lhbl || !lvbl)) |=> (red == '0 && green == '0 && blue == '0))
        else $error("RGB not zero after a blanked pixel tick");

    rgb_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({red, green, blue}))
        else $error("RGB output has unknown bits");

endmodule

bind video_top video_checker u_checker (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .cen6  ( cen6  ),
    .lhbl  ( lhbl  ),
    .lvbl  ( lvbl  ),
    .red   ( red   ),
    .green ( green ),
    .blue  ( blue  )
);

/* tests/video_tb.sv */
// ####################################################################
// Tile video testbench
// ROM models, table driven CPU and scan stimulus, pixel reference model
// ####################################################################

`timescale 1ns/1ps

module video_tb;

    localparam int OP_WR     = 0;
    localparam int OP_RD     = 1;
    localparam int OP_PAL    = 2;
    localparam int OP_SCROLL = 3;
    localparam int OP_FLIP   = 4;
    localparam int OP_SCAN   = 5;
    localparam int N_OPS     = 24;

    logic clk;
    logic rst_n;
    logic cen6;
    logic flip;
    logic cpu_wr;
    logic cpu_rd;
    logic char_cs;
    logic scr_cs;
    logic lhbl;
    logic lvbl;
    logic prom_red_we;
    logic prom_green_we;
    logic prom_blue_we;
    logic [1:0]                scrpos_cs;
    video_pkg::h_t             h;
    video_pkg::v_t             v;
    video_pkg::cpu_addr_t      cpu_addr;
    video_pkg::byte_t          cpu_din;
    video_pkg::pal_idx_t       prog_addr;
    video_pkg::rgb_t           prog_din;
    video_pkg::byte_t          chram_dout;
    video_pkg::byte_t          scram_dout;
    video_pkg::char_rom_addr_t char_addr;
    video_pkg::scr_rom_addr_t  scr_addr;
    video_pkg::rgb_t           red;
    video_pkg::rgb_t           green;
    video_pkg::rgb_t           blue;
    logic [15:0]               char_data = '0;
    logic [23:0]               scrom_data = '0;
    logic [15:0]               char_q = '0;
    logic [23:0]               scr_q = '0;

    // Model copies of ROMs, tile RAMs and palette
    logic [15:0]      char_rom [0:4095];
    logic [23:0]      scr_rom  [0:16383];
    video_pkg::byte_t chram_m  [0:2047];
    video_pkg::byte_t scram_m  [0:1023];
    video_pkg::rgb_t  pal_r    [0:255];
    video_pkg::rgb_t  pal_g    [0:255];
    video_pkg::rgb_t  pal_b    [0:255];
    logic [8:0]       scroll_m;

    int op_kind [0:N_OPS-1];
    int op_addr [0:N_OPS-1];
    int op_data [0:N_OPS-1];
    int op_exp  [0:N_OPS-1];
    int n_ops;
    int errors;
    int i;
    logic timed_out;
    logic [15:0] lfsr_state;

    tb_clock u_clock (
        .clk ( clk )
    );

    video_top dut0 (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cen6          ( cen6          ),
        .h             ( h             ),
        .v             ( v             ),
        .flip          ( flip          ),
        .cpu_addr      ( cpu_addr      ),
        .cpu_din       ( cpu_din       ),
        .cpu_wr        ( cpu_wr        ),
        .cpu_rd        ( cpu_rd        ),
        .char_cs       ( char_cs       ),
        .scr_cs        ( scr_cs        ),
        .scrpos_cs     ( scrpos_cs     ),
        .chram_dout    ( chram_dout    ),
        .scram_dout    ( scram_dout    ),
        .char_addr     ( char_addr     ),
        .char_data     ( char_data     ),
        .scr_addr      ( scr_addr      ),
        .scrom_data    ( scrom_data    ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .prog_addr     ( prog_addr     ),
        .prog_din      ( prog_din      ),
        .prom_red_we   ( prom_red_we   ),
        .prom_green_we ( prom_green_we ),
        .prom_blue_we  ( prom_blue_we  ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          )
    );

    // Graphics ROM models with one clock of read latency
    always @(posedge clk) begin
        char_q <= char_rom[char_addr];
        scr_q  <= scr_rom[scr_addr];
    end

    always @(negedge clk) begin
        char_data  <= char_q;
        scrom_data <= scr_q;
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        galois_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [23:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            val = {val[22:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expv);
        if (got !== expv) begin
            errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expv);
        end
    endtask

    function automatic int blank_spec(input int start, input int len, input int use_v);
        return start + (len << 10) + (use_v << 20);
    endfunction

    task automatic add_entry(input int kind, input int addr, input int data, input int expv);
        op_kind[n_ops] = kind;
        op_addr[n_ops] = addr;
        op_data[n_ops] = data;
        op_exp[n_ops]  = expv;
        n_ops++;
    endtask

    task automatic fill_roms;
        int k;
        logic [23:0] bits;
        for (k = 0; k < 4096; k++) begin
            take_bits(16, bits);
            char_rom[k] = bits[15:0];
        end
        for (k = 0; k < 16384; k++) begin
            take_bits(24, bits);
            scr_rom[k] = bits;
        end
    endtask

    task automatic write_ram(input logic scr, input logic [10:0] a, input logic [7:0] d);
        @(negedge clk);
        cpu_addr = a;
        cpu_din  = d;
        char_cs  = !scr;
        scr_cs   = scr;
        cpu_wr   = 1'b1;
        @(negedge clk);
        cpu_wr  = 1'b0;
        char_cs = 1'b0;
        scr_cs  = 1'b0;
        if (scr) begin
            scram_m[a[9:0]] = d;
        end else begin
            chram_m[a] = d;
        end
    endtask

    task automatic read_ram(input logic scr, input logic [10:0] a, input logic [7:0] expv);
        @(negedge clk);
        cpu_addr = a;
        char_cs  = !scr;
        scr_cs   = scr;
        cpu_rd   = 1'b1;
        @(negedge clk);
        cpu_rd  = 1'b0;
        char_cs = 1'b0;
        scr_cs  = 1'b0;
        check_value(scr ? "scram_dout" : "chram_dout",
                    16'(scr ? scram_dout : chram_dout), 16'(expv));
        // Read data must hold across a write to the same entry
        write_ram(scr, a, ~expv);
        repeat (2) @(negedge clk);
        check_value(scr ? "scram_dout" : "chram_dout",
                    16'(scr ? scram_dout : chram_dout), 16'(expv));
    endtask

    task automatic fill_tile_rams;
        int k;
        logic [23:0] bits;
        for (k = 0; k < 2048; k++) begin
            take_bits(8, bits);
            write_ram(1'b0, 11'(k), bits[7:0]);
        end
        for (k = 0; k < 1024; k++) begin
            take_bits(8, bits);
            write_ram(1'b1, 11'(k), bits[7:0]);
        end
    endtask

    task automatic load_palette;
        int k;
        logic [23:0] bits;
        for (k = 0; k < 256; k++) begin
            take_bits(12, bits);
            pal_r[k] = bits[11:8];
            pal_g[k] = bits[7:4];
            pal_b[k] = bits[3:0];
            @(negedge clk);
            prog_addr   = 8'(k);
            prog_din    = pal_r[k];
            prom_red_we = 1'b1;
            @(negedge clk);
            prom_red_we   = 1'b0;
            prog_din      = pal_g[k];
            prom_green_we = 1'b1;
            @(negedge clk);
            prom_green_we = 1'b0;
            prog_din      = pal_b[k];
            prom_blue_we  = 1'b1;
            @(negedge clk);
            prom_blue_we = 1'b0;
        end
    endtask

    task automatic set_scroll(input logic [8:0] pos);
        @(negedge clk);
        cpu_din   = pos[7:0];
        scrpos_cs = 2'b01;
        cpu_wr    = 1'b1;
        @(negedge clk);
        cpu_din   = {7'd0, pos[8]};
        scrpos_cs = 2'b10;
        @(negedge clk);
        cpu_wr    = 1'b0;
        scrpos_cs = 2'b00;
        scroll_m  = pos;
    endtask

    // Palette index of a screen column from the layer and priority rules
    function automatic video_pkg::pal_idx_t pixel_index(input logic [7:0] col,
                                                        input logic [7:0] line);
        logic [7:0]  hp;
        logic [7:0]  vp;
        logic [8:0]  vs;
        logic [9:0]  centry;
        logic [8:0]  sentry;
        logic [7:0]  ccode;
        logic [7:0]  cattr;
        logic [7:0]  scode;
        logic [7:0]  sattr;
        logic [15:0] cd;
        logic [23:0] sd;
        logic [2:0]  bitn;
        logic [1:0]  ccol;
        logic [2:0]  scol;
        hp     = flip ? ~col : col;
        vp     = flip ? ~line : line;
        bitn   = 3'd7 - hp[2:0];
        centry = {vp[7:3], hp[7:3]};
        ccode  = chram_m[{1'b0, centry}];
        cattr  = chram_m[{1'b1, centry}];
        cd     = char_rom[{cattr[7], ccode, vp[2:0]}];
        ccol   = {cd[8 + bitn], cd[bitn]};
        vs     = {1'b0, vp} + scroll_m;
        sentry = {vs[8:4], hp[7:4]};
        scode  = scram_m[{1'b0, sentry}];
        sattr  = scram_m[{1'b1, sentry}];
        sd     = scr_rom[{sattr[7], scode, vs[3:0], hp[3]}];
        scol   = {sd[16 + bitn], sd[8 + bitn], sd[bitn]};
        if (ccol == 2'd0) begin
            pixel_index = {2'b00, sattr[2:0], scol};
        end else begin
            pixel_index = video_pkg::char_pal_base + {4'd0, cattr[1:0], ccol};
        end
    endfunction

    // One scanned line with the visible window on h 2 to 257
    task automatic scan_line(input logic [7:0] line, input int spec);
        int hv;
        int bstart;
        int blen;
        int use_v;
        logic in_win;
        video_pkg::pal_idx_t idx;
        video_pkg::rgb_t er;
        video_pkg::rgb_t eg;
        video_pkg::rgb_t eb;
        bstart = spec & 1023;
        blen   = (spec >> 10) & 1023;
        use_v  = (spec >> 20) & 1;
        v      = line;
        for (hv = 0; hv < 264; hv++) begin
            @(negedge clk);
            h      = 9'(hv);
            in_win = hv >= bstart && hv < bstart + blen;
            lhbl   = hv >= 2 && hv < 258 && !(in_win && use_v == 0);
            lvbl   = !(in_win && use_v == 1);
            cen6   = 1'b1;
            @(negedge clk);
            cen6 = 1'b0;
            if (!lhbl || !lvbl) begin
                er = '0;
                eg = '0;
                eb = '0;
            end else begin
                idx = pixel_index(8'(hv - 2), line);
                er  = pal_r[idx];
                eg  = pal_g[idx];
                eb  = pal_b[idx];
            end
            check_value($sformatf("red h=%0d v=%0d", hv, line), 16'(red), 16'(er));
            check_value($sformatf("green h=%0d v=%0d", hv, line), 16'(green), 16'(eg));
            check_value($sformatf("blue h=%0d v=%0d", hv, line), 16'(blue), 16'(eb));
        end
    endtask

    task automatic wait_reset_clear;
        int n;
        n = 0;
        while ({red, green, blue, chram_dout, scram_dout} !== '0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if ({red, green, blue, chram_dout, scram_dout} !== '0) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: outputs did not clear within 10 clocks of reset");
        end
    endtask

    task automatic apply_entry(input int k);
        case (op_kind[k])
            OP_WR:     write_ram(op_addr[k] >= 'h1000, 11'(op_addr[k]), 8'(op_data[k]));
            OP_RD:     read_ram(op_addr[k] >= 'h1000, 11'(op_addr[k]), 8'(op_exp[k]));
            OP_PAL:    load_palette();
            OP_SCROLL: set_scroll(9'(op_data[k]));
            OP_FLIP: begin
                @(negedge clk);
                flip = op_data[k] != 0;
            end
            default:   scan_line(8'(op_addr[k]), op_data[k]);
        endcase
    endtask

    // Scroll RAM targets carry address bit 12
    task automatic build_table;
        add_entry(OP_WR, 'h005, 'h3c, 0);
        add_entry(OP_WR, 'h405, 'h81, 0);
        add_entry(OP_RD, 'h005, 0, 'h3c);
        add_entry(OP_RD, 'h405, 0, 'h81);
        add_entry(OP_WR, 'h1010, 'h5a, 0);
        add_entry(OP_WR, 'h13ff, 'ha7, 0);
        add_entry(OP_RD, 'h1010, 0, 'h5a);
        add_entry(OP_RD, 'h13ff, 0, 'ha7);
        add_entry(OP_PAL, 0, 0, 0);
        add_entry(OP_SCAN, 'h10, 0, 0);
        add_entry(OP_SCAN, 'h47, 0, 0);
        add_entry(OP_SCROLL, 0, 'h023, 0);
        add_entry(OP_SCAN, 'h10, 0, 0);
        add_entry(OP_SCROLL, 0, 'h1f0, 0);
        add_entry(OP_SCAN, 'h30, 0, 0);
        add_entry(OP_FLIP, 0, 1, 0);
        add_entry(OP_SCAN, 'h10, 0, 0);
        add_entry(OP_SCAN, 'h9b, 0, 0);
        add_entry(OP_FLIP, 0, 0, 0);
        add_entry(OP_SCAN, 'h55, blank_spec(100, 40, 0), 0);
        add_entry(OP_SCAN, 'h56, blank_spec(200, 20, 1), 0);
    endtask

    initial begin
        lfsr_state    = 16'd86;
        errors        = 0;
        n_ops         = 0;
        timed_out     = 1'b0;
        scroll_m      = '0;
        rst_n         = 1'b0;
        cen6          = 1'b0;
        h             = '0;
        v             = '0;
        flip          = 1'b0;
        cpu_addr      = '0;
        cpu_din       = '0;
        cpu_wr        = 1'b0;
        cpu_rd        = 1'b0;
        char_cs       = 1'b0;
        scr_cs        = 1'b0;
        scrpos_cs     = 2'b00;
        lhbl          = 1'b0;
        lvbl          = 1'b0;
        prog_addr     = '0;
        prog_din      = '0;
        prom_red_we   = 1'b0;
        prom_green_we = 1'b0;
        prom_blue_we  = 1'b0;
        fill_roms();
        build_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait_reset_clear();
        if (!timed_out) begin
            fill_tile_rams();
            for (i = 0; i < n_ops; i++) begin
                apply_entry(i);
            end
        end
        $display("Run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/video_pkg.sv
verilog/video_char.sv
verilog/video_scroll.sv
verilog/video_colmix.sv
verilog/video_top.sv
tests/tb_clock.sv
tests/video_checker.sv
tests/video_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the tile video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module video_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vvideo_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Finished with no errors$"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
